/* logic/crc_consts.svh */
/*
 * CRC accelerator constants
 * Register word offsets (HADDR bits 4:2), reset values and CR field positions
 */
`ifndef CRC_CONSTS_SVH
`define CRC_CONSTS_SVH

// Register word offsets
`define CRC_DR      3'd0
`define CRC_IDR     3'd1
`define CRC_CR      3'd2
`define CRC_INIT    3'd4
`define CRC_POL     3'd5

// Reset values
`define INIT_RESET  32'hffff_ffff
`define POL_RESET   32'h04c1_1db7
`define CR_RESET    8'h00

// CR fields, restart bit is write only
`define CR_RESTART  0
`define CR_POLY_LO  3
`define CR_POLY_HI  4
`define CR_REVIN_LO 5
`define CR_REVIN_HI 6
`define CR_REVOUT   7
// Bits that CR keeps
`define CR_WMASK    8'hf8

`endif

/* logic/ahb_pkg.sv */
/*
 * AHB-Lite bus types
 * Transfer type, transfer size and response encodings
 */
`default_nettype none

package ahb_pkg;

	// HTRANS encoding
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// HSIZE encoding, also the size of a buffered word
	typedef enum logic [2:0]
	{
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_t;

	// HRESP encoding
	typedef enum logic
	{
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_t;

endpackage

`default_nettype wire

/* logic/crc_pkg.sv */
/*
 * CRC engine types
 * Engine FSM states, polynomial widths and input bit reversal modes
 */
`default_nettype none

package crc_pkg;

	// Engine FSM
	typedef enum logic [1:0]
	{
		ST_IDLE = 2'b00,
		ST_LOAD = 2'b01,
		ST_STEP = 2'b10
	} engine_state_t;

	// Polynomial width, as held in CR bits 4:3
	typedef enum logic [1:0]
	{
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_t;

	// Input bit reversal unit, as held in CR bits 6:5
	typedef enum logic [1:0]
	{
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_t;

endpackage

`default_nettype wire

/* logic/host_interface.sv */
/*
 * AHB-Lite slave front end of the CRC accelerator
 * Registers the address phase, decodes the register map, holds CR,
 * drives the read mux and inserts the DR, INIT and restart wait states
 */
`timescale 1ns/1ps
`default_nettype none
`include "crc_consts.svh"

module host_interface
(
	input  wire                      HCLK,
	input  wire                      HRESETn,
	input  wire                      HSELx,
	input  wire [31:0]               HADDR,
	input  wire ahb_pkg::htrans_t    HTRANS,
	input  wire                      HWRITE,
	input  wire ahb_pkg::hsize_t     HSIZE,
	input  wire [31:0]               HWDATA,
	input  wire                      HREADY,
	input  wire [31:0]               crc_out,
	input  wire [31:0]               crc_init_out,
	input  wire [31:0]               crc_poly_out,
	input  wire [7:0]                crc_idr_out,
	input  wire                      buffer_full,
	input  wire                      engine_busy,
	output logic [31:0]              HRDATA,
	output logic                     HREADYOUT,
	output ahb_pkg::hresp_t          HRESP,
	output logic [31:0]              bus_wr,
	output ahb_pkg::hsize_t          bus_size,
	output crc_pkg::rev_in_t         rev_in_type,
	output crc_pkg::poly_size_t      crc_poly_size,
	output logic                     rev_out_type,
	output logic                     buffer_write_en,
	output logic                     crc_init_en,
	output logic                     crc_poly_en,
	output logic                     crc_idr_en,
	output logic                     reset_chain
);

	// Address phase pipeline
	logic [2:0]        haddr_q;
	ahb_pkg::hsize_t   hsize_q;
	ahb_pkg::htrans_t  htrans_q;
	logic              hwrite_q;
	logic              hsel_q;
	// Control register, restart bit never stored
	logic [7:0]        cr_q;
	logic              sample_bus;
	logic              xfer_pending;
	logic              write_en;
	logic              read_en;
	// Per register requests in the data phase
	logic              dr_wr_req;
	logic              dr_rd_req;
	logic              idr_wr_req;
	logic              cr_wr_req;
	logic              init_wr_req;
	logic              pol_wr_req;
	logic              restart_req;
	logic              cr_wr_en;
	logic              read_wait;
	logic              reset_pending;

	//////////////////////////////
	// Address phase
	//////////////////////////////

	// Take the address phase only when the bus moves on
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_q   <= 1'b0;
			htrans_q <= ahb_pkg::IDLE;
			hwrite_q <= 1'b0;
			haddr_q  <= 3'd0;
			hsize_q  <= ahb_pkg::BYTE;
		end
		else if (sample_bus)
		begin
			hsel_q   <= HSELx;
			htrans_q <= HTRANS;
			hwrite_q <= HWRITE;
			// Word offset only, byte lanes are not decoded
			haddr_q  <= HADDR[4:2];
			hsize_q  <= HSIZE;
		end
	end

	//////////////////////////////
	// Data phase decode
	//////////////////////////////

	// SEQ and BUSY are ignored
	assign xfer_pending = hsel_q && (htrans_q == ahb_pkg::NONSEQ);
	assign write_en     = xfer_pending && hwrite_q;
	assign read_en      = xfer_pending && !hwrite_q;

	assign dr_wr_req    = write_en && (haddr_q == `CRC_DR);
	assign dr_rd_req    = read_en  && (haddr_q == `CRC_DR);
	assign idr_wr_req   = write_en && (haddr_q == `CRC_IDR);
	assign cr_wr_req    = write_en && (haddr_q == `CRC_CR);
	assign init_wr_req  = write_en && (haddr_q == `CRC_INIT);
	assign pol_wr_req   = write_en && (haddr_q == `CRC_POL);
	// HWDATA is live in the data phase
	assign restart_req  = cr_wr_req && HWDATA[`CR_RESTART];

	// DR read needs the last word folded in
	assign read_wait     = buffer_full || engine_busy;
	// CRC reload must not race a running step
	assign reset_pending = engine_busy;

	// Wait states
	assign HREADYOUT = !((dr_wr_req && buffer_full) ||
	                     (dr_rd_req && read_wait) ||
	                     ((init_wr_req || restart_req) && reset_pending));

	// Never an error
	assign HRESP = ahb_pkg::OKAY;

	// Strobes fire on the clock that ends the data phase
	assign buffer_write_en = dr_wr_req   && HREADYOUT;
	assign crc_init_en     = init_wr_req && HREADYOUT;
	assign crc_poly_en     = pol_wr_req  && HREADYOUT;
	assign crc_idr_en      = idr_wr_req  && HREADYOUT;
	assign reset_chain     = restart_req && HREADYOUT;
	assign cr_wr_en        = cr_wr_req   && HREADYOUT;

	// Write data goes out unregistered
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_q;

	//////////////////////////////
	// Control register
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= `CR_RESET;
		else if (cr_wr_en)
			cr_q <= HWDATA[7:0] & `CR_WMASK;
	end

	assign crc_poly_size = crc_pkg::poly_size_t'(cr_q[`CR_POLY_HI:`CR_POLY_LO]);
	assign rev_in_type   = crc_pkg::rev_in_t'(cr_q[`CR_REVIN_HI:`CR_REVIN_LO]);
	assign rev_out_type  = cr_q[`CR_REVOUT];

	// Read mux
	always_comb
	begin
		case (haddr_q)
			`CRC_DR:   HRDATA = crc_out;
			`CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			`CRC_CR:   HRDATA = {24'h0, cr_q};
			`CRC_INIT: HRDATA = crc_init_out;
			`CRC_POL:  HRDATA = crc_poly_out;
			default:   HRDATA = 32'h0;
		endcase
	end

	// A sampled transfer that is not a selected NONSEQ never stalls its data phase
	a_ready_when_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
		sample_bus && !(HSELx && (HTRANS == ahb_pkg::NONSEQ)) |=> HREADYOUT);

	// Register strobes only follow a sampled selected write
	a_enable_needs_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
		sample_bus && !(HSELx && HWRITE && (HTRANS == ahb_pkg::NONSEQ)) |=>
		!(buffer_write_en || crc_init_en || crc_poly_en || crc_idr_en || reset_chain));

endmodule

`default_nettype wire

/* logic/input_buffer.sv */
/*
 * DR input buffer
 * Captures a DR write with input bit reversal and offers it to the engine
 * over valid/ready, keeping an engine side copy once it is taken
 */
`timescale 1ns/1ps
`default_nettype none

module input_buffer
(
	input  wire                    HCLK,
	input  wire                    HRESETn,
	input  wire                    buffer_write_en,
	input  wire [31:0]             bus_wr,
	input  wire ahb_pkg::hsize_t   bus_size,
	input  wire crc_pkg::rev_in_t  rev_in_type,
	input  wire                    word_ready,
	output logic                   buffer_full,
	output logic                   word_valid,
	output logic [31:0]            word_data,
	output ahb_pkg::hsize_t        word_size
);

	logic              valid_q;
	logic [31:0]       buf_data_q;
	ahb_pkg::hsize_t   buf_size_q;
	logic [31:0]       rev_data;
	// Index flip inside the reversal unit
	logic [4:0]        rev_mask;

	//////////////////////////////
	// Input bit reversal
	//////////////////////////////

	// Reversal runs over the whole bus word whatever the size
	always_comb
	begin
		case (rev_in_type)
			crc_pkg::REV_BYTE: rev_mask = 5'd7;
			crc_pkg::REV_HALF: rev_mask = 5'd15;
			crc_pkg::REV_WORD: rev_mask = 5'd31;
			default:           rev_mask = 5'd0;
		endcase
	end

	// Bit i takes bit i xor mask, mirroring each unit
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			rev_data[i] = bus_wr[i ^ rev_mask];
	end

	//////////////////////////////
	// Buffer and handshake
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			valid_q <= 1'b0;
		else if (buffer_write_en)
			valid_q <= 1'b1;
		else if (word_valid && word_ready)
			valid_q <= 1'b0;
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			buf_data_q <= rev_data;
			buf_size_q <= bus_size;
		end
		// Engine copy, so the buffer is free for the next write
		if (word_valid && word_ready)
		begin
			word_data <= buf_data_q;
			word_size <= buf_size_q;
		end
	end

	assign word_valid  = valid_q;
	assign buffer_full = valid_q;

	// The host side must stall a DR write while full
	a_no_write_when_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

endmodule

`default_nettype wire

/* logic/byte_counter.sv */
/*
 * Byte counter of the CRC engine
 * Counts the bytes left in the current word and names the byte lane
 */
`timescale 1ns/1ps
`default_nettype none

module byte_counter
(
	input  wire                   HCLK,
	input  wire                   HRESETn,
	input  wire                   count_load,
	input  wire                   count_step,
	input  wire ahb_pkg::hsize_t  word_size,
	output logic [1:0]            byte_sel,
	output logic                  last_byte
);

	// Bytes left, up to four
	logic [2:0] count_q;
	// Current lane, low byte first
	logic [1:0] lane_q;
	logic [2:0] load_count;

	always_comb
	begin
		case (word_size)
			ahb_pkg::BYTE: load_count = 3'd1;
			ahb_pkg::HALF: load_count = 3'd2;
			default:       load_count = 3'd4;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			count_q <= 3'd0;
			lane_q  <= 2'd0;
		end
		else if (count_load)
		begin
			count_q <= load_count;
			lane_q  <= 2'd0;
		end
		else if (count_step)
		begin
			count_q <= count_q - 3'd1;
			lane_q  <= lane_q + 2'd1;
		end
	end

	assign byte_sel  = lane_q;
	assign last_byte = (count_q == 3'd1);

	// The FSM stops stepping once the word is used up
	a_no_step_at_zero: assert property (@(posedge HCLK) disable iff (!HRESETn)
		count_step |-> (count_q != 3'd0));

endmodule

`default_nettype wire

/* logic/crc_control.sv */
/*
 * CRC engine control FSM
 * Takes one word over valid/ready, loads the byte counter,
 * then issues one CRC step per byte
 */
`timescale 1ns/1ps
`default_nettype none

module crc_control
(
	input  wire   HCLK,
	input  wire   HRESETn,
	input  wire   word_valid,
	input  wire   last_byte,
	output logic  word_ready,
	output logic  count_load,
	output logic  count_step,
	output logic  crc_step,
	output logic  engine_busy
);

	crc_pkg::engine_state_t state_q;
	crc_pkg::engine_state_t state_d;

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			crc_pkg::ST_IDLE:
			begin
				// Handshake with the buffer
				if (word_valid)
					state_d = crc_pkg::ST_LOAD;
			end
			crc_pkg::ST_LOAD:
				state_d = crc_pkg::ST_STEP;
			crc_pkg::ST_STEP:
			begin
				if (last_byte)
					state_d = crc_pkg::ST_IDLE;
			end
			default:
				state_d = crc_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			state_q <= crc_pkg::ST_IDLE;
		else
			state_q <= state_d;
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	// Back-pressure, one word at a time in the engine
	assign word_ready  = (state_q == crc_pkg::ST_IDLE);
	// Size is in the engine copy one clock after the handshake
	assign count_load  = (state_q == crc_pkg::ST_LOAD);
	// One byte per clock
	assign count_step  = (state_q == crc_pkg::ST_STEP);
	assign crc_step    = (state_q == crc_pkg::ST_STEP);
	assign engine_busy = (state_q != crc_pkg::ST_IDLE);

	// Every step is entered from a load or continues a step
	a_step_after_load: assert property (@(posedge HCLK) disable iff (!HRESETn)
		crc_step |-> ($past(state_q) inside {crc_pkg::ST_LOAD, crc_pkg::ST_STEP}));

endmodule

`default_nettype wire

/* logic/crc_datapath.sv */
/*
 * CRC datapath
 * Holds CRC, INIT, POL and IDR, folds one byte per step MSB first
 * at 32, 16, 8 or 7 bits and applies output bit reversal
 */
`timescale 1ns/1ps
`default_nettype none
`include "crc_consts.svh"

module crc_datapath
(
	input  wire                       HCLK,
	input  wire                       HRESETn,
	input  wire [31:0]                bus_wr,
	input  wire                       crc_init_en,
	input  wire                       crc_poly_en,
	input  wire                       crc_idr_en,
	input  wire                       reset_chain,
	input  wire                       crc_step,
	input  wire [31:0]                word_data,
	input  wire [1:0]                 byte_sel,
	input  wire crc_pkg::poly_size_t  crc_poly_size,
	input  wire                       rev_out_type,
	output logic [31:0]               crc_out,
	output logic [31:0]               crc_init_out,
	output logic [31:0]               crc_poly_out,
	output logic [7:0]                crc_idr_out
);

	logic [31:0] crc_q;
	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	logic [31:0] width_mask;
	logic [4:0]  top_bit;
	logic [7:0]  data_byte;
	logic [31:0] crc_tmp;
	logic [31:0] crc_next;
	logic [31:0] crc_masked;
	logic        feedback;

	//////////////////////////////
	// Width selection
	//////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			crc_pkg::P16:
			begin
				width_mask = 32'h0000_ffff;
				top_bit    = 5'd15;
			end
			crc_pkg::P8:
			begin
				width_mask = 32'h0000_00ff;
				top_bit    = 5'd7;
			end
			crc_pkg::P7:
			begin
				width_mask = 32'h0000_007f;
				top_bit    = 5'd6;
			end
			default:
			begin
				width_mask = 32'hffff_ffff;
				top_bit    = 5'd31;
			end
		endcase
	end

	//////////////////////////////
	// Byte step
	//////////////////////////////

	// Lane picked by the byte counter
	assign data_byte = word_data[{byte_sel, 3'b000} +: 8];

	// Eight shifts MSB first, top polynomial bit implicit
	always_comb
	begin
		crc_tmp  = crc_q & width_mask;
		feedback = 1'b0;
		for (int i = 7; i >= 0; i--)
		begin
			feedback = crc_tmp[top_bit] ^ data_byte[i];
			crc_tmp  = (crc_tmp << 1) & width_mask;
			if (feedback)
				crc_tmp = crc_tmp ^ (poly_q & width_mask);
		end
		crc_next = crc_tmp;
	end

	//////////////////////////////
	// Registers
	//////////////////////////////

	// CRC keeps the full load, the width mask is applied on use
	// so a restart that also changes the width sees the new one
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_q <= `INIT_RESET;
		else if (crc_init_en)
			crc_q <= bus_wr;
		else if (reset_chain)
			crc_q <= init_q;
		else if (crc_step)
			crc_q <= crc_next;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= `INIT_RESET;
			poly_q <= `POL_RESET;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr;
			// IDR is a plain 8 bit scratch register
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
		end
	end

	// Output reversal spans all 32 bits
	assign crc_masked   = crc_q & width_mask;
	assign crc_out      = rev_out_type ? {<<{crc_masked}} : crc_masked;
	assign crc_init_out = init_q;
	assign crc_poly_out = poly_q;
	assign crc_idr_out  = idr_q;

endmodule

`default_nettype wire

/* logic/crc_ahb_top.sv */
/*
 * CRC accelerator top level
 * AHB-Lite slave, input buffer, byte counter, engine FSM and datapath
 */
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_top
(
	input  wire                    HCLK,
	input  wire                    HRESETn,
	input  wire                    HSELx,
	input  wire [31:0]             HADDR,
	input  wire ahb_pkg::htrans_t  HTRANS,
	input  wire                    HWRITE,
	input  wire ahb_pkg::hsize_t   HSIZE,
	input  wire [31:0]             HWDATA,
	input  wire                    HREADY,
	output logic [31:0]            HRDATA,
	output logic                   HREADYOUT,
	output ahb_pkg::hresp_t        HRESP
);

	// Host to datapath and buffer
	logic [31:0]          bus_wr;
	ahb_pkg::hsize_t      bus_size;
	crc_pkg::rev_in_t     rev_in_type;
	crc_pkg::poly_size_t  crc_poly_size;
	logic                 rev_out_type;
	logic                 buffer_write_en;
	logic                 crc_init_en;
	logic                 crc_poly_en;
	logic                 crc_idr_en;
	logic                 reset_chain;
	// Readback
	logic [31:0]          crc_out;
	logic [31:0]          crc_init_out;
	logic [31:0]          crc_poly_out;
	logic [7:0]           crc_idr_out;
	// Buffer handshake
	logic                 buffer_full;
	logic                 word_valid;
	logic                 word_ready;
	logic [31:0]          word_data;
	ahb_pkg::hsize_t      word_size;
	// Engine
	logic                 count_load;
	logic                 count_step;
	logic [1:0]           byte_sel;
	logic                 last_byte;
	logic                 crc_step;
	logic                 engine_busy;

	host_interface host_interface_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSELx           (HSELx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HWRITE          (HWRITE),
		.HSIZE           (HSIZE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.engine_busy     (engine_busy),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.rev_in_type     (rev_in_type),
		.crc_poly_size   (crc_poly_size),
		.rev_out_type    (rev_out_type),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_poly_en     (crc_poly_en),
		.crc_idr_en      (crc_idr_en),
		.reset_chain     (reset_chain)
	);

	input_buffer input_buffer_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.buffer_write_en (buffer_write_en),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.rev_in_type     (rev_in_type),
		.word_ready      (word_ready),
		.buffer_full     (buffer_full),
		.word_valid      (word_valid),
		.word_data       (word_data),
		.word_size       (word_size)
	);

	byte_counter byte_counter_i
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.count_load (count_load),
		.count_step (count_step),
		.word_size  (word_size),
		.byte_sel   (byte_sel),
		.last_byte  (last_byte)
	);

	crc_control crc_control_i
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.word_valid  (word_valid),
		.last_byte   (last_byte),
		.word_ready  (word_ready),
		.count_load  (count_load),
		.count_step  (count_step),
		.crc_step    (crc_step),
		.engine_busy (engine_busy)
	);

	crc_datapath crc_datapath_i
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.bus_wr        (bus_wr),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.crc_idr_en    (crc_idr_en),
		.reset_chain   (reset_chain),
		.crc_step      (crc_step),
		.word_data     (word_data),
		.byte_sel      (byte_sel),
		.crc_poly_size (crc_poly_size),
		.rev_out_type  (rev_out_type),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out)
	);

endmodule

`default_nettype wire

/* bench/crc_ahb_tb.sv */
/*
 * Testbench of the AHB-Lite CRC accelerator
 * Seeded random AHB master, register and CRC reference model,
 * value checks and a watchdog sized from the transfer count
 */
`timescale 1ns/1ps
`default_nettype none
`include "crc_consts.svh"

module crc_ahb_tb;

	localparam int clk_period       = 100;
	localparam int n_reg_rounds     = 8;
	localparam int n_crc32_words    = 16;
	localparam int n_rand_rounds    = 12;
	localparam int max_rand_writes  = 8;
	localparam int n_b2b_rounds     = 4;
	localparam int n_b2b_writes     = 4;
	localparam int n_restart_rounds = 4;
	// Upper bound of bus transfers over all tests
	localparam int total_xfers = 5 + 6 * n_reg_rounds + 12 + n_crc32_words + 1 +
		n_rand_rounds * (4 + max_rand_writes) + n_b2b_rounds * (n_b2b_writes + 1) +
		6 * n_restart_rounds;

	logic               HCLK;
	logic               HRESETn;
	logic               hsel;
	logic [31:0]        haddr;
	ahb_pkg::htrans_t   htrans;
	logic               hwrite;
	ahb_pkg::hsize_t    hsize;
	logic [31:0]        hwdata;
	logic               hready;
	logic [31:0]        hrdata;
	logic               hreadyout;
	ahb_pkg::hresp_t    hresp;

	int seed;
	int n_checks;
	int n_errors;
	int n_xfers;
	int n_waits;
	// Reference model state
	logic [7:0]  m_cr;
	logic [31:0] m_init;
	logic [31:0] m_pol;
	logic [7:0]  m_idr;
	logic [31:0] m_crc;

	crc_ahb_top dut_i
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSELx     (hsel),
		.HADDR     (haddr),
		.HTRANS    (htrans),
		.HWRITE    (hwrite),
		.HSIZE     (hsize),
		.HWDATA    (hwdata),
		.HREADY    (hready),
		.HRDATA    (hrdata),
		.HREADYOUT (hreadyout),
		.HRESP     (hresp)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #(clk_period / 2) HCLK = ~HCLK;
	end

	// Generous budget per transfer, stalls included
	initial
	begin
		repeat (10 + total_xfers * 20) @(posedge HCLK);
		$display("Timeout: the bus transfers did not complete in the expected time");
		$display(">>> FAIL");
		$finish;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int poly_width(input logic [1:0] psize);
		case (psize)
			crc_pkg::P16: return 16;
			crc_pkg::P8:  return 8;
			crc_pkg::P7:  return 7;
			default:      return 32;
		endcase
	endfunction

	// Mirror the bits inside each unit of the chosen reversal mode
	function automatic logic [31:0] reverse_units(input logic [31:0] d, input logic [1:0] mode);
		int unit;
		logic [31:0] r;
		case (mode)
			crc_pkg::REV_BYTE: unit = 8;
			crc_pkg::REV_HALF: unit = 16;
			crc_pkg::REV_WORD: unit = 32;
			default:           unit = 1;
		endcase
		for (int i = 0; i < 32; i++)
			r[i] = d[(i / unit) * unit + unit - 1 - i % unit];
		return r;
	endfunction

	// One byte MSB first, polynomial top bit implicit
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] b,
		input logic [1:0] psize, input logic [31:0] poly);
		int width;
		logic [31:0] mask;
		logic [31:0] c;
		logic top;
		width = poly_width(psize);
		mask  = 32'hffff_ffff >> (32 - width);
		c     = crc & mask;
		for (int i = 7; i >= 0; i--)
		begin
			top = c[width - 1] ^ b[i];
			c   = (c << 1) & mask;
			if (top)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	// DR view, masked to the width and mirrored over 32 bits on request
	function automatic logic [31:0] expected_dr();
		logic [31:0] v;
		logic [31:0] r;
		v = m_crc & (32'hffff_ffff >> (32 - poly_width(m_cr[4:3])));
		for (int i = 0; i < 32; i++)
			r[i] = v[31 - i];
		return m_cr[7] ? r : v;
	endfunction

	//////////////////////////////
	// Checks and bus tasks
	//////////////////////////////

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		n_checks++;
		if (got !== expected)
		begin
			n_errors++;
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, got, expected);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (n_errors == errors_before)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, n_errors - errors_before);
	endtask

	// Single NONSEQ transfer, outputs sampled on the falling edge
	task automatic bus_xfer(input logic write, input ahb_pkg::hsize_t size,
		input logic [2:0] offset, input logic [31:0] wdata, output logic [31:0] rdata);
		hsel   = 1'b1;
		haddr  = {27'd0, offset, 2'b00};
		htrans = ahb_pkg::NONSEQ;
		hwrite = write;
		hsize  = size;
		@(negedge HCLK);
		while (hreadyout !== 1'b1)
			@(negedge HCLK);
		@(posedge HCLK);
		#1;
		// Data phase
		hsel   = 1'b0;
		htrans = ahb_pkg::IDLE;
		hwrite = 1'b0;
		hwdata = write ? wdata : 32'h0;
		@(negedge HCLK);
		while (hreadyout !== 1'b1)
		begin
			n_waits++;
			@(negedge HCLK);
		end
		rdata = hrdata;
		check_equal("HRESP", hresp, ahb_pkg::OKAY);
		@(posedge HCLK);
		#1;
		n_xfers++;
	endtask

	task automatic write_reg(input logic [2:0] offset, input logic [31:0] data);
		logic [31:0] unused;
		bus_xfer(1'b1, ahb_pkg::WORD, offset, data, unused);
		case (offset)
			`CRC_IDR: m_idr = data[7:0];
			`CRC_CR:
			begin
				m_cr = {data[7:3], 3'b000};
				if (data[0])
					m_crc = m_init;
			end
			// INIT also reloads the CRC
			`CRC_INIT:
			begin
				m_init = data;
				m_crc  = data;
			end
			`CRC_POL: m_pol = data;
			default: ;
		endcase
	endtask

	// Narrow data is replicated on all lanes, as an AHB master does
	task automatic write_dr(input ahb_pkg::hsize_t size, input logic [31:0] data);
		logic [31:0] bus;
		logic [31:0] word;
		logic [31:0] unused;
		int n;
		case (size)
			ahb_pkg::BYTE:
			begin
				bus = {4{data[7:0]}};
				n   = 1;
			end
			ahb_pkg::HALF:
			begin
				bus = {2{data[15:0]}};
				n   = 2;
			end
			default:
			begin
				bus = data;
				n   = 4;
			end
		endcase
		bus_xfer(1'b1, size, `CRC_DR, bus, unused);
		word = reverse_units(bus, m_cr[6:5]);
		// Low byte first
		for (int k = 0; k < n; k++)
			m_crc = fold_byte(m_crc, word[8 * k +: 8], m_cr[4:3], m_pol);
	endtask

	task automatic read_check(input string name, input logic [2:0] offset,
		input logic [31:0] expected);
		logic [31:0] rdata;
		bus_xfer(1'b0, ahb_pkg::WORD, offset, 32'h0, rdata);
		check_equal(name, rdata, expected);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin : run_tests
		int errs;
		int n;
		int w0;
		logic [31:0] r;
		logic [7:0] cr;
		ahb_pkg::hsize_t sz;
		seed     = 32'hdefb_a795;
		n_checks = 0;
		n_errors = 0;
		n_xfers  = 0;
		n_waits  = 0;
		HRESETn  = 1'b0;
		hsel     = 1'b0;
		haddr    = 32'h0;
		htrans   = ahb_pkg::IDLE;
		hwrite   = 1'b0;
		hsize    = ahb_pkg::WORD;
		hwdata   = 32'h0;
		// Single slave, nothing else holds the bus
		hready   = 1'b1;
		m_cr     = 8'h00;
		m_init   = 32'hffff_ffff;
		m_pol    = 32'h04c1_1db7;
		m_idr    = 8'h00;
		m_crc    = 32'hffff_ffff;
		repeat (10) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		errs = n_errors;
		read_check("INIT", `CRC_INIT, 32'hffff_ffff);
		read_check("POL", `CRC_POL, 32'h04c1_1db7);
		read_check("CR", `CRC_CR, 32'h0);
		read_check("IDR", `CRC_IDR, 32'h0);
		read_check("DR", `CRC_DR, 32'hffff_ffff);
		report_test("1 reset values", errs);

		errs = n_errors;
		for (int k = 0; k < n_reg_rounds; k++)
		begin
			write_reg(`CRC_IDR, $random(seed));
			write_reg(`CRC_INIT, $random(seed));
			write_reg(`CRC_POL, $random(seed));
			read_check("IDR", `CRC_IDR, {24'h0, m_idr});
			read_check("INIT", `CRC_INIT, m_init);
			read_check("POL", `CRC_POL, m_pol);
		end
		report_test("2 register readback", errs);

		// CR still at reset, so plain CRC-32 MSB first
		errs = n_errors;
		write_reg(`CRC_POL, 32'h04c1_1db7);
		write_reg(`CRC_INIT, 32'hffff_ffff);
		for (int k = 0; k < 9; k++)
			write_dr(ahb_pkg::BYTE, 32'h31 + k);
		// Known check value of the string 123456789
		read_check("DR check string", `CRC_DR, 32'h0376_e6e7);
		for (int k = 0; k < n_crc32_words; k++)
			write_dr(ahb_pkg::WORD, $random(seed));
		read_check("DR crc32", `CRC_DR, expected_dr());
		report_test("3 crc32 words", errs);

		errs = n_errors;
		for (int k = 0; k < n_rand_rounds; k++)
		begin
			write_reg(`CRC_POL, $random(seed));
			r = $random(seed);
			write_reg(`CRC_CR, {24'h0, r[7:3], 3'b000});
			write_reg(`CRC_INIT, $random(seed));
			r = $random(seed);
			n = 1 + r[2:0];
			for (int j = 0; j < n; j++)
			begin
				r = $random(seed);
				case (r[1:0])
					2'd0:    sz = ahb_pkg::BYTE;
					2'd1:    sz = ahb_pkg::HALF;
					default: sz = ahb_pkg::WORD;
				endcase
				write_dr(sz, $random(seed));
			end
			read_check("DR random config", `CRC_DR, expected_dr());
		end
		report_test("4 random configurations", errs);

		// Third write in a row finds the buffer full
		errs = n_errors;
		w0   = n_waits;
		for (int k = 0; k < n_b2b_rounds; k++)
		begin
			for (int j = 0; j < n_b2b_writes; j++)
				write_dr(ahb_pkg::WORD, $random(seed));
			read_check("DR back to back", `CRC_DR, expected_dr());
		end
		check_equal("wait states seen", n_waits > w0, 1);
		report_test("5 back to back writes", errs);

		errs = n_errors;
		for (int k = 0; k < n_restart_rounds; k++)
		begin
			write_dr(ahb_pkg::WORD, $random(seed));
			read_check("DR before restart", `CRC_DR, expected_dr());
			write_dr(ahb_pkg::WORD, $random(seed));
			r  = $random(seed);
			cr = {r[7:3], 3'b001};
			write_reg(`CRC_CR, {24'h0, cr});
			read_check("DR after restart", `CRC_DR, expected_dr());
			read_check("CR", `CRC_CR, {24'h0, cr & 8'hfe});
		end
		report_test("6 restart", errs);

		$display("Checks %0d, errors %0d, transfers %0d, wait states %0d",
			n_checks, n_errors, n_xfers, n_waits);
		if (n_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/ahb_pkg.sv
logic/crc_pkg.sv
logic/host_interface.sv
logic/input_buffer.sv
logic/byte_counter.sv
logic/crc_control.sv
logic/crc_datapath.sv
logic/crc_ahb_top.sv
bench/crc_ahb_tb.sv
